/* src/equihash_pkg.sv */
/*
  Common widths and types for the equihash index list checker.
  Every module of the checker imports this package.
*/
package equihash_pkg;

  // Width of one input stream word
  localparam int DAT_BITS = 16;

  // Width of one packed solution index
  localparam int SOL_BITS = 12;

  typedef logic [DAT_BITS-1:0] sol_word_t;
  typedef logic [SOL_BITS-1:0] sol_idx_t;

  // One unpacked index on its way to the checks
  typedef struct packed {
    sol_idx_t idx;
    logic     first;
    logic     last;
  } idx_beat_t;

  // Failure mask reported after the last index
  typedef struct packed {
    logic bad_idx_order;
    logic duplicate_fnd;
  } result_mask_t;

endpackage

/* src/sol_intake.sv */
/*
  Input side of the checker. Counts the words of each solution, drops
  the header words and forwards the solution words to the unpacker.
  Intake stays closed after the last word until the result is out.
*/
`timescale 1ns/1ns

module sol_intake
  import equihash_pkg::*;
#(
  parameter int LIST_LEN  = 16,
  parameter int HDR_WORDS = 4
) (
  input  logic      i_clk,
  input  logic      i_rst,
  input  logic      i_val,
  input  sol_word_t i_dat,
  input  logic      i_eop,
  input  logic      i_space,
  input  logic      i_done,
  output logic      o_rdy,
  output logic      o_word_val,
  output sol_word_t o_word
);

  localparam int SOL_WORDS = (LIST_LEN * SOL_BITS + DAT_BITS - 1) / DAT_BITS;
  localparam int ALL_WORDS = HDR_WORDS + SOL_WORDS;
  localparam int CNT_BITS  = $clog2(ALL_WORDS + 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_HDR,
    ST_DATA,
    ST_WAIT
  } state_t;

  state_t              state;
  logic [CNT_BITS-1:0] word_cnt;
  logic                rdy_open;
  logic                accept;
  logic                is_sol;

  // Unpacker back-pressure closes intake directly
  assign o_rdy  = rdy_open & i_space;
  assign accept = i_val & o_rdy;

  // Words past the solution length are dropped as well
  assign is_sol = ((state == ST_DATA) || (HDR_WORDS == 0 && state == ST_IDLE)) &&
                  (word_cnt < CNT_BITS'(ALL_WORDS));

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state      <= ST_IDLE;
      word_cnt   <= '0;
      rdy_open   <= 1'b0;
      o_word_val <= 1'b0;
    end else begin
      o_word_val <= accept && is_sol;
      if (accept && word_cnt != CNT_BITS'(ALL_WORDS))
        word_cnt <= word_cnt + 1'b1;

      case (state)
        ST_IDLE: begin
          rdy_open <= 1'b1;
          if (accept)
            state <= (HDR_WORDS > 1) ? ST_HDR : ST_DATA;
        end
        ST_HDR: begin
          if (accept && (word_cnt + 1 >= HDR_WORDS))
            state <= ST_DATA;
        end
        ST_WAIT: begin
          // Result is out, open for the next solution
          if (i_done) begin
            state    <= ST_IDLE;
            word_cnt <= '0;
            rdy_open <= 1'b1;
          end
        end
        default: ;
      endcase

      if (accept && i_eop) begin
        state    <= ST_WAIT;
        rdy_open <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept)
      o_word <= i_dat;
  end

endmodule

/* src/index_unpack.sv */
/*
  Slices the solution words into indices, most significant bit first.
  Words are appended below the unused bits of a left-aligned bit buffer
  and one index per cycle is taken from the top.
*/
`timescale 1ns/1ns

module index_unpack
  import equihash_pkg::*;
#(
  parameter int LIST_LEN = 16
) (
  input  logic      i_clk,
  input  logic      i_rst,
  input  logic      i_word_val,
  input  sol_word_t i_word,
  output logic      o_space,
  output logic      o_beat_val,
  output idx_beat_t o_beat
);

  // Room for the word in flight on top of a nearly full buffer
  localparam int BUF_BITS = 2 * DAT_BITS + SOL_BITS;
  localparam int CNT_BITS = $clog2(BUF_BITS + 1);
  localparam int IDX_BITS = $clog2(LIST_LEN);

  logic [BUF_BITS-1:0] bit_buf;
  logic [BUF_BITS-1:0] buf_shift;
  logic [BUF_BITS-1:0] word_ext;
  logic [CNT_BITS-1:0] fill;
  logic [CNT_BITS-1:0] fill_rem;
  logic [IDX_BITS-1:0] idx_cnt;
  logic                take;
  logic                take_last;

  always_comb begin
    take      = (fill >= CNT_BITS'(SOL_BITS));
    take_last = take && (idx_cnt == IDX_BITS'(LIST_LEN - 1));
    buf_shift = take ? (bit_buf << SOL_BITS) : bit_buf;
    fill_rem  = take ? (fill - CNT_BITS'(SOL_BITS)) : fill;
    // New word lands right below the bits still in use
    word_ext  = {i_word, {(BUF_BITS - DAT_BITS){1'b0}}} >> fill_rem;
  end

  assign o_space = (fill < CNT_BITS'(DAT_BITS));

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      bit_buf    <= '0;
      fill       <= '0;
      idx_cnt    <= '0;
      o_beat_val <= 1'b0;
    end else begin
      o_beat_val <= take;
      if (take)
        idx_cnt <= idx_cnt + 1'b1;

      // Padding after the last index is thrown away
      if (take_last) begin
        bit_buf <= '0;
        fill    <= '0;
      end else if (i_word_val) begin
        bit_buf <= buf_shift | word_ext;
        fill    <= fill_rem + CNT_BITS'(DAT_BITS);
      end else begin
        bit_buf <= buf_shift;
        fill    <= fill_rem;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (take) begin
      o_beat.idx   <= bit_buf[BUF_BITS-1 -: SOL_BITS];
      o_beat.first <= (idx_cnt == '0);
      o_beat.last  <= take_last;
    end
  end

endmodule

/* src/order_check.sv */
/*
  Leaf order check of the index tree. Keeps the first index of the
  current left subtree at every level and compares it with the first
  index of the right sibling when that one arrives.
*/
`timescale 1ns/1ns

module order_check
  import equihash_pkg::*;
#(
  parameter int LIST_LEN = 16
) (
  input  logic      i_clk,
  input  logic      i_rst,
  input  logic      i_beat_val,
  input  idx_beat_t i_beat,
  output logic      o_done,
  output logic      o_bad_order
);

  localparam int LEVELS = $clog2(LIST_LEN);

  logic [LEVELS-1:0] cnt;
  logic [LEVELS-1:0] n;
  sol_idx_t          left_first [LEVELS];
  logic              fail_now;

  always_comb begin
    n        = i_beat.first ? '0 : cnt;
    fail_now = 1'b0;
    for (int k = 0; k < LEVELS; k++) begin
      // First leaf of a right subtree at level k
      if ((n & ((1 << (k + 1)) - 1)) == (1 << k) && i_beat.idx <= left_first[k])
        fail_now = 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      cnt         <= '0;
      o_done      <= 1'b0;
      o_bad_order <= 1'b0;
    end else begin
      o_done <= i_beat_val && i_beat.last;
      if (i_beat_val) begin
        cnt         <= n + 1'b1;
        o_bad_order <= (i_beat.first ? 1'b0 : o_bad_order) | fail_now;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_beat_val) begin
      for (int k = 0; k < LEVELS; k++) begin
        if ((n & ((1 << (k + 1)) - 1)) == 0)
          left_first[k] <= i_beat.idx;
      end
    end
  end

endmodule

/* src/dup_check.sv */
/*
  Duplicate index check. Every index of a solution is stored with a
  valid bit and each new index is compared against all stored ones.
*/
`timescale 1ns/1ns

module dup_check
  import equihash_pkg::*;
#(
  parameter int LIST_LEN = 16
) (
  input  logic      i_clk,
  input  logic      i_rst,
  input  logic      i_beat_val,
  input  idx_beat_t i_beat,
  output logic      o_done,
  output logic      o_dup
);

  localparam int IDX_BITS = $clog2(LIST_LEN);

  sol_idx_t            seen [LIST_LEN];
  logic [LIST_LEN-1:0] seen_vld;
  logic [LIST_LEN-1:0] hit;
  logic [IDX_BITS-1:0] wr_ptr;
  logic [IDX_BITS-1:0] ptr;

  always_comb begin
    ptr = i_beat.first ? '0 : wr_ptr;
    // Entries of the previous solution never match a first beat
    for (int i = 0; i < LIST_LEN; i++)
      hit[i] = seen_vld[i] && !i_beat.first && (seen[i] == i_beat.idx);
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      seen_vld <= '0;
      wr_ptr   <= '0;
      o_done   <= 1'b0;
      o_dup    <= 1'b0;
    end else begin
      o_done <= i_beat_val && i_beat.last;
      if (i_beat_val) begin
        wr_ptr   <= ptr + 1'b1;
        seen_vld <= (i_beat.first ? '0 : seen_vld) | (LIST_LEN'(1) << ptr);
        o_dup    <= (i_beat.first ? 1'b0 : o_dup) | (|hit);
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_beat_val)
      seen[ptr] <= i_beat.idx;
  end

endmodule

/* src/result_collect.sv */
/*
  Waits for both checks to finish, then drives the failure mask with a
  single valid pulse and tells the intake that the solution is done.
*/
`timescale 1ns/1ns

module result_collect
  import equihash_pkg::*;
(
  input  logic         i_clk,
  input  logic         i_rst,
  input  logic         i_order_done,
  input  logic         i_bad_order,
  input  logic         i_dup_done,
  input  logic         i_dup,
  output result_mask_t o_mask,
  output logic         o_mask_val,
  output logic         o_done
);

  logic order_seen;
  logic order_bad;
  logic dup_seen;
  logic dup_bad;
  logic order_have;
  logic dup_have;

  // A pulse in this cycle counts as seen
  assign order_have = order_seen | i_order_done;
  assign dup_have   = dup_seen | i_dup_done;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      order_seen <= 1'b0;
      order_bad  <= 1'b0;
      dup_seen   <= 1'b0;
      dup_bad    <= 1'b0;
      o_mask     <= '0;
      o_mask_val <= 1'b0;
      o_done     <= 1'b0;
    end else begin
      o_mask_val <= 1'b0;
      o_done     <= 1'b0;
      if (i_order_done) begin
        order_seen <= 1'b1;
        order_bad  <= i_bad_order;
      end
      if (i_dup_done) begin
        dup_seen <= 1'b1;
        dup_bad  <= i_dup;
      end
      if (order_have && dup_have) begin
        o_mask.bad_idx_order <= i_order_done ? i_bad_order : order_bad;
        o_mask.duplicate_fnd <= i_dup_done ? i_dup : dup_bad;
        o_mask_val           <= 1'b1;
        o_done               <= 1'b1;
        order_seen           <= 1'b0;
        dup_seen             <= 1'b0;
      end
    end
  end

endmodule

/* src/equihash_verif_top.sv */
/*
  Top level of the equihash index list checker.
  Takes header and solution words on a valid/ready stream and reports a
  failure mask with a one-cycle valid pulse after the last index.
*/
`timescale 1ns/1ns

module equihash_verif_top
  import equihash_pkg::*;
#(
  parameter int LIST_LEN  = 16,
  parameter int HDR_WORDS = 4
) (
  input  logic         i_clk,
  input  logic         i_rst,
  input  logic         i_val,
  input  sol_word_t    i_dat,
  // Start of packet, the header is found by counting words from idle
  input  logic         i_sop,
  input  logic         i_eop,
  output logic         o_rdy,
  output result_mask_t o_mask,
  output logic         o_mask_val
);

  logic      word_val;
  sol_word_t word;
  logic      space;
  logic      beat_val;
  idx_beat_t beat;
  logic      order_done;
  logic      bad_order;
  logic      dup_done;
  logic      dup;
  logic      res_done;

  sol_intake #(
    .LIST_LEN  (LIST_LEN),
    .HDR_WORDS (HDR_WORDS)
  ) u_intake (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_val      (i_val),
    .i_dat      (i_dat),
    .i_eop      (i_eop),
    .i_space    (space),
    .i_done     (res_done),
    .o_rdy      (o_rdy),
    .o_word_val (word_val),
    .o_word     (word)
  );

  index_unpack #(
    .LIST_LEN (LIST_LEN)
  ) u_unpack (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_word_val (word_val),
    .i_word     (word),
    .o_space    (space),
    .o_beat_val (beat_val),
    .o_beat     (beat)
  );

  order_check #(
    .LIST_LEN (LIST_LEN)
  ) u_order (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_beat_val  (beat_val),
    .i_beat      (beat),
    .o_done      (order_done),
    .o_bad_order (bad_order)
  );

  dup_check #(
    .LIST_LEN (LIST_LEN)
  ) u_dup (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_beat_val (beat_val),
    .i_beat     (beat),
    .o_done     (dup_done),
    .o_dup      (dup)
  );

  result_collect u_result (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_order_done (order_done),
    .i_bad_order  (bad_order),
    .i_dup_done   (dup_done),
    .i_dup        (dup),
    .o_mask       (o_mask),
    .o_mask_val   (o_mask_val),
    .o_done       (res_done)
  );

endmodule

/* test/equihash_verif_asserts.sv */
/*
  Concurrent assertions on the top-level timing of the checker.
  Bound into equihash_verif_top, failures are counted for the testbench.
*/
`timescale 1ns/1ns

module equihash_verif_asserts (
  input logic i_clk,
  input logic i_rst,
  input logic i_val,
  input logic i_eop,
  input logic o_rdy,
  input logic o_mask_val
);

  int   assert_fails = 0;
  logic wait_res;

  // High from the cycle after an accepted last word up to the result pulse
  always_ff @(posedge i_clk) begin
    if (i_rst)
      wait_res <= 1'b0;
    else if (i_val && o_rdy && i_eop)
      wait_res <= 1'b1;
    else if (o_mask_val)
      wait_res <= 1'b0;
  end

  mask_val_single: assert property (@(posedge i_clk) disable iff (i_rst)
    o_mask_val |=> !o_mask_val)
    else begin
      assert_fails++;
      $error("o_mask_val high for two cycles");
    end

  rdy_closed: assert property (@(posedge i_clk) disable iff (i_rst)
    wait_res |-> !o_rdy)
    else begin
      assert_fails++;
      $error("o_rdy high while a result is pending");
    end

  mask_quiet_in_reset: assert property (@(posedge i_clk)
    (i_rst && $past(i_rst)) |-> !o_mask_val)
    else begin
      assert_fails++;
      $error("o_mask_val high during reset");
    end

endmodule

bind equihash_verif_top equihash_verif_asserts u_asserts (
  .i_clk      (i_clk),
  .i_rst      (i_rst),
  .i_val      (i_val),
  .i_eop      (i_eop),
  .o_rdy      (o_rdy),
  .o_mask_val (o_mask_val)
);

/* test/equihash_verif_tb.sv */
/*
  Testbench for the equihash index list checker. Sends random solutions
  built as ordered, duplicated, swapped or fully random index lists with
  random i_val gaps, and compares each result mask with a tree model.
*/
`timescale 1ns/1ns

module equihash_verif_tb
  import equihash_pkg::*;
;

  localparam int LIST_LEN     = 16;
  localparam int HDR_WORDS    = 4;
  localparam int LEVELS       = $clog2(LIST_LEN);
  localparam int SOL_WORDS    = (LIST_LEN * SOL_BITS + DAT_BITS - 1) / DAT_BITS;
  localparam int ALL_WORDS    = HDR_WORDS + SOL_WORDS;
  localparam int PACK_BITS    = SOL_WORDS * DAT_BITS;
  localparam int NUM_RUNS     = 40;
  localparam int RDY_TIMEOUT  = 200;
  localparam int MASK_TIMEOUT = 500;

  logic         i_clk;
  logic         i_rst;
  logic         i_val;
  sol_word_t    i_dat;
  logic         i_sop;
  logic         i_eop;
  logic         o_rdy;
  result_mask_t o_mask;
  logic         o_mask_val;

  sol_idx_t  idx_list [LIST_LEN];
  sol_word_t stream [ALL_WORDS];
  int        check_cnt;
  int        err_cnt;
  int        timeout_cnt;
  logic      abort;

  equihash_verif_top #(
    .LIST_LEN  (LIST_LEN),
    .HDR_WORDS (HDR_WORDS)
  ) DUT (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_val      (i_val),
    .i_dat      (i_dat),
    .i_sop      (i_sop),
    .i_eop      (i_eop),
    .o_rdy      (o_rdy),
    .o_mask     (o_mask),
    .o_mask_val (o_mask_val)
  );

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  task automatic check_val(input int got, input int exp, input string what);
    check_cnt++;
    if (got != exp) begin
      err_cnt++;
      $display("CHECK FAILED at %0t ns: %s, got %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic swap_halves(input int base, input int half);
    sol_idx_t tmp;
    for (int i = 0; i < half; i++) begin
      tmp                      = idx_list[base + i];
      idx_list[base + i]        = idx_list[base + half + i];
      idx_list[base + half + i] = tmp;
    end
  endtask

  // Distinct random indices, then bottom-up subtree swaps give tree order
  task automatic make_ordered();
    sol_idx_t cand;
    logic     clash;
    int       half;
    for (int i = 0; i < LIST_LEN; i++) begin
      do begin
        cand  = sol_idx_t'($urandom);
        clash = 1'b0;
        for (int j = 0; j < i; j++)
          if (idx_list[j] == cand)
            clash = 1'b1;
      end while (clash);
      idx_list[i] = cand;
    end
    for (int k = 0; k < LEVELS; k++) begin
      half = 1 << k;
      for (int b = 0; b < LIST_LEN; b += 2 * half)
        if (idx_list[b] > idx_list[b + half])
          swap_halves(b, half);
    end
  endtask

  task automatic build_solution(input int kind);
    int src;
    int dst;
    int half;
    make_ordered();
    case (kind)
      1: begin
        src           = $urandom % LIST_LEN;
        dst           = (src + 1 + $urandom % (LIST_LEN - 1)) % LIST_LEN;
        idx_list[dst] = idx_list[src];
      end
      2: begin
        half = 1 << ($urandom % LEVELS);
        swap_halves(($urandom % (LIST_LEN / (2 * half))) * 2 * half, half);
      end
      3: begin
        // A narrow value range makes duplicates likely
        for (int i = 0; i < LIST_LEN; i++)
          idx_list[i] = ($urandom % 2) ? sol_idx_t'($urandom % 32) : sol_idx_t'($urandom);
      end
      default: ;
    endcase
  endtask

  function automatic result_mask_t expected_mask();
    result_mask_t m;
    int           half;
    m = '0;
    for (int i = 0; i < LIST_LEN; i++)
      for (int j = i + 1; j < LIST_LEN; j++)
        if (idx_list[i] == idx_list[j])
          m.duplicate_fnd = 1'b1;
    // First leaf of each right subtree against its left sibling
    for (int k = 0; k < LEVELS; k++) begin
      half = 1 << k;
      for (int n = half; n < LIST_LEN; n += 2 * half)
        if (idx_list[n] <= idx_list[n - half])
          m.bad_idx_order = 1'b1;
    end
    return m;
  endfunction

  task automatic pack_stream();
    logic [PACK_BITS-1:0] bits;
    bits = '0;
    for (int i = 0; i < LIST_LEN; i++)
      bits[PACK_BITS-1-i*SOL_BITS -: SOL_BITS] = idx_list[i];
    for (int h = 0; h < HDR_WORDS; h++)
      stream[h] = sol_word_t'($urandom);
    for (int w = 0; w < SOL_WORDS; w++)
      stream[HDR_WORDS + w] = bits[PACK_BITS-1-w*DAT_BITS -: DAT_BITS];
  endtask

  // Holds one word until it is accepted, with random idle cycles
  task automatic send_word(input sol_word_t w, input logic sop, input logic eop);
    int   waited;
    logic done;
    waited = 0;
    done   = 1'b0;
    while (!done && !abort) begin
      i_val = ($urandom % 4) != 0;
      i_dat = i_val ? w : sol_word_t'($urandom);
      i_sop = i_val & sop;
      i_eop = i_val & eop;
      done  = i_val && o_rdy;
      @(posedge i_clk);
      #1;
      waited++;
      if (!done && waited > RDY_TIMEOUT) begin
        $display("Timeout: o_rdy stayed low for %0d cycles at %0t ns", waited, $time);
        timeout_cnt++;
        abort = 1'b1;
      end
    end
    i_val = 1'b0;
    i_sop = 1'b0;
    i_eop = 1'b0;
  endtask

  task automatic send_solution();
    for (int w = 0; w < ALL_WORDS && !abort; w++)
      send_word(stream[w], w == 0, w == ALL_WORDS - 1);
  endtask

  task automatic wait_result(input result_mask_t exp, output result_mask_t got);
    int waited;
    waited = 0;
    got    = '0;
    while (!o_mask_val && waited < MASK_TIMEOUT) begin
      check_val(o_rdy, 0, "o_rdy while result pending");
      @(posedge i_clk);
      #1;
      waited++;
    end
    if (!o_mask_val) begin
      $display("Timeout: no o_mask_val within %0d cycles at %0t ns", waited, $time);
      timeout_cnt++;
      abort = 1'b1;
    end else begin
      got = o_mask;
      @(posedge i_clk);
      #1;
      check_val(o_mask_val, 0, "o_mask_val pulse width");
      check_val(o_mask, exp, "o_mask held after pulse");
    end
  endtask

  initial begin
    int           kind;
    result_mask_t got;
    result_mask_t exp;
    void'($urandom(9));
    check_cnt   = 0;
    err_cnt     = 0;
    timeout_cnt = 0;
    abort       = 1'b0;
    i_rst       = 1'b1;
    i_val       = 1'b0;
    i_dat       = '0;
    i_sop       = 1'b0;
    i_eop       = 1'b0;
    repeat (4) @(posedge i_clk);
    #1;
    i_rst = 1'b0;
    check_val(o_rdy, 0, "o_rdy in first cycle after reset");
    check_val(o_mask_val, 0, "o_mask_val after reset");
    @(posedge i_clk);
    #1;
    check_val(o_rdy, 1, "o_rdy open after reset");

    // Solutions follow each other as soon as intake reopens
    for (int run = 0; run < NUM_RUNS && !abort; run++) begin
      kind = (run < 4) ? run : int'($urandom % 4);
      build_solution(kind);
      exp = expected_mask();
      pack_stream();
      send_solution();
      if (!abort)
        wait_result(exp, got);
      if (!abort) begin
        check_val(got.bad_idx_order, exp.bad_idx_order,
                  $sformatf("run %0d kind %0d bad_idx_order", run, kind));
        check_val(got.duplicate_fnd, exp.duplicate_fnd,
                  $sformatf("run %0d kind %0d duplicate_fnd", run, kind));
      end
    end

    $display("Checks %0d, mismatches %0d, timeouts %0d, assertion failures %0d",
             check_cnt, err_cnt, timeout_cnt, DUT.u_asserts.assert_fails);
    if (err_cnt == 0 && timeout_cnt == 0 && DUT.u_asserts.assert_fails == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

/* equihash_verif.f */
src/equihash_pkg.sv
src/sol_intake.sv
src/index_unpack.sv
src/order_check.sv
src/dup_check.sv
src/result_collect.sv
src/equihash_verif_top.sv
test/equihash_verif_asserts.sv
test/equihash_verif_tb.sv
